// File: hw/csr_pkg.sv
package csr_pkg;

    typedef logic [31:0] word_t;
    typedef logic [63:0] dword_t;

    // implemented machine-mode and user counter CSRs
    typedef enum logic [11:0] {
        CSR_MSTATUS       = 12'h300,
        CSR_MISA          = 12'h301,
        CSR_MIE           = 12'h304,
        CSR_MTVEC         = 12'h305,
        CSR_MCOUNTINHIBIT = 12'h320,
        CSR_MSCRATCH      = 12'h340,
        CSR_MEPC          = 12'h341,
        CSR_MCAUSE        = 12'h342,
        CSR_MIP           = 12'h344,
        CSR_PMPCFG0       = 12'h3A0,
        CSR_PMPCFG1       = 12'h3A1,
        CSR_PMPCFG2       = 12'h3A2,
        CSR_PMPADDR0      = 12'h3B0,
        CSR_PMPADDR1      = 12'h3B1,
        CSR_PMPADDR2      = 12'h3B2,
        CSR_PMPADDR3      = 12'h3B3,
        CSR_PMPADDR4      = 12'h3B4,
        CSR_PMPADDR5      = 12'h3B5,
        CSR_PMPADDR6      = 12'h3B6,
        CSR_PMPADDR7      = 12'h3B7,
        CSR_PMPADDR8      = 12'h3B8,
        CSR_MCYCLE        = 12'hB00,
        CSR_MINSTRET      = 12'hB02,
        CSR_MCYCLEH       = 12'hB80,
        CSR_MINSTRETH     = 12'hB82,
        CSR_CYCLE         = 12'hC00,
        CSR_TIME          = 12'hC01,
        CSR_INSTRET       = 12'hC02,
        CSR_CYCLEH        = 12'hC80,
        CSR_TIMEH         = 12'hC81,
        CSR_INSTRETH      = 12'hC82,
        CSR_MVENDORID     = 12'hF11,
        CSR_MARCHID       = 12'hF12,
        CSR_MIMPID        = 12'hF13,
        CSR_MHARTID       = 12'hF14
    } csr_addr_e;

    typedef enum logic [1:0] {
        MTVEC_DIRECT   = 2'd0,
        MTVEC_VECTORED = 2'd1
    } mtvec_mode_e;

    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;

    localparam int MIE_MSI_BIT = 3;
    localparam int MIE_MTI_BIT = 7;
    localparam int MIE_MEI_BIT = 11;

    localparam word_t CAUSE_M_EXTERNAL = 32'd11;

    localparam word_t MISA_VALUE   = 32'h4000_0100; // MXL=1, I only
    localparam word_t MIMPID_VALUE = 32'd1;

    localparam int PMP_ENTRIES = 9;

    typedef enum logic [1:0] {
        PMP_OFF   = 2'd0,
        PMP_TOR   = 2'd1,
        PMP_NA4   = 2'd2,
        PMP_NAPOT = 2'd3
    } pmp_mode_e;

    typedef struct packed {
        logic       lock;
        logic [1:0] zero;
        pmp_mode_e  mode;
        logic [2:0] rwx;   // bit 0 read, bit 1 write, bit 2 execute
    } pmp_cfg_t;

    localparam logic [2:0] PMP_R = 3'b001;
    localparam logic [2:0] PMP_W = 3'b010;
    localparam logic [2:0] PMP_X = 3'b100;

    // word addresses, i.e. byte address >> 2
    localparam word_t PMP_ADDR [0:PMP_ENTRIES-1] = '{
        32'h0000_0000,  // bios
        32'h0000_0400,
        32'h0400_0000,  // system ram
        32'h0400_0400,
        32'h0800_0000,  // video ram
        32'h0800_0400,
        32'h3FC0_0001,  // 0xFF000004
        32'h3FC0_0002,  // 0xFF000008
        32'h3FFF_FFFF
    };

    localparam pmp_cfg_t PMP_CFG [0:PMP_ENTRIES-1] = '{
        '{lock: 1'b1, zero: 2'b00, mode: PMP_NAPOT, rwx: PMP_R | PMP_X},
        '{lock: 1'b1, zero: 2'b00, mode: PMP_OFF,   rwx: 3'b000},
        '{lock: 1'b1, zero: 2'b00, mode: PMP_NAPOT, rwx: PMP_R | PMP_W},
        '{lock: 1'b1, zero: 2'b00, mode: PMP_OFF,   rwx: 3'b000},
        '{lock: 1'b1, zero: 2'b00, mode: PMP_NAPOT, rwx: PMP_R | PMP_W},
        '{lock: 1'b1, zero: 2'b00, mode: PMP_OFF,   rwx: 3'b000},
        '{lock: 1'b1, zero: 2'b00, mode: PMP_NA4,   rwx: PMP_R | PMP_W},
        '{lock: 1'b1, zero: 2'b00, mode: PMP_NA4,   rwx: PMP_R},
        '{lock: 1'b1, zero: 2'b00, mode: PMP_TOR,   rwx: 3'b000}
    };

endpackage

// File: hw/csr_counters.sv
`timescale 1ns/1ns

module csr_counters (
    input  logic            clk_i,
    input  logic            arst_n_i,
    input  logic            retired_i,
    input  csr_pkg::word_t  inhibit_i,
    input  csr_pkg::word_t  wr_data_i,
    input  logic            wr_cycle_lo_i,
    input  logic            wr_cycle_hi_i,
    input  logic            wr_instret_lo_i,
    input  logic            wr_instret_hi_i,
    input  logic            wr_time_lo_i,
    input  logic            wr_time_hi_i,
    output csr_pkg::dword_t cycle_o,
    output csr_pkg::dword_t instret_o,
    output csr_pkg::dword_t time_o
);
    import csr_pkg::*;

    dword_t cycle_q;
    dword_t instret_q;
    dword_t time_q;

    dword_t cycle_adv;   // value after this edge's increment
    dword_t instret_adv;
    dword_t time_adv;

    // a half write replaces one word, the other word keeps its advanced value
    function automatic dword_t merge_half(
        input dword_t adv,
        input logic   wr_lo,
        input logic   wr_hi,
        input word_t  data
    );
        dword_t val;
        val = adv;
        if (wr_lo)
            val[31:0] = data;
        if (wr_hi)
            val[63:32] = data;
        return val;
    endfunction

    assign cycle_adv   = inhibit_i[0] ? cycle_q : cycle_q + 64'd1;
    assign instret_adv = (retired_i && !inhibit_i[2]) ? instret_q + 64'd1 : instret_q;
    assign time_adv    = time_q + 64'd1;  // never inhibited

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cycle_q   <= '0;
            instret_q <= '0;
            time_q    <= '0;
        end else begin
            cycle_q   <= merge_half(cycle_adv, wr_cycle_lo_i, wr_cycle_hi_i, wr_data_i);
            instret_q <= merge_half(instret_adv, wr_instret_lo_i, wr_instret_hi_i, wr_data_i);
            time_q    <= merge_half(time_adv, wr_time_lo_i, wr_time_hi_i, wr_data_i);
        end
    end

    assign cycle_o   = cycle_q;
    assign instret_o = instret_q;
    assign time_o    = time_q;

endmodule

// File: hw/csr_trap_ctrl.sv
`timescale 1ns/1ns

module csr_trap_ctrl (
    input  logic           clk_i,
    input  logic           arst_n_i,
    input  logic           interrupt_i,
    input  logic           meie_i,
    input  csr_pkg::word_t mtvec_i,
    input  logic           trap_i,
    input  csr_pkg::word_t trap_pc_i,
    input  csr_pkg::word_t trap_cause_i,
    input  logic           mret_i,
    input  logic           jmp_accept_i,
    input  csr_pkg::word_t wr_data_i,
    input  logic           wr_mstatus_i,
    input  logic           wr_mepc_i,
    output logic           jmp_req_o,
    output csr_pkg::word_t jmp_addr_o,
    output csr_pkg::word_t mstatus_o,
    output csr_pkg::word_t mepc_o,
    output csr_pkg::word_t mcause_o
);
    import csr_pkg::*;

    logic        mie_q;   // global interrupt enable
    logic        mpie_q;  // enable before the last trap
    word_t       mepc_q;
    word_t       mcause_q;

    logic        irq_take;
    logic        trap_take;
    logic        accept;
    mtvec_mode_e mode;
    word_t       base_addr;

    assign irq_take  = interrupt_i && meie_i && mie_q;
    assign trap_take = trap_i || irq_take;  // both enter through mtvec
    assign jmp_req_o = trap_take || mret_i;
    assign accept    = jmp_accept_i && jmp_req_o;

    assign mode      = mtvec_mode_e'(mtvec_i[1:0]);
    assign base_addr = {mtvec_i[31:2], 2'b00};

    // trap beats mret, sync trap beats interrupt
    always_comb begin
        jmp_addr_o = '0;
        if (trap_take) begin
            jmp_addr_o = base_addr;
            if (!trap_i && mode == MTVEC_VECTORED)
                jmp_addr_o = base_addr + (CAUSE_M_EXTERNAL << 2);
        end else if (mret_i) begin
            jmp_addr_o = mepc_q;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mie_q    <= 1'b0;
            mpie_q   <= 1'b0;
            mepc_q   <= '0;
            mcause_q <= '0;
        end else begin
            // csr writes win over the trap update
            if (wr_mstatus_i) begin
                mie_q  <= wr_data_i[MSTATUS_MIE_BIT];
                mpie_q <= wr_data_i[MSTATUS_MPIE_BIT];
            end else if (accept && trap_take) begin
                mie_q  <= 1'b0;
                mpie_q <= mie_q;
            end else if (accept && mret_i) begin
                mie_q  <= mpie_q;
                mpie_q <= 1'b1;
            end

            if (wr_mepc_i)
                mepc_q <= wr_data_i;
            else if (accept && trap_take)
                mepc_q <= trap_pc_i;
            else if (accept && mret_i)
                mepc_q <= '0;

            if (accept && trap_i)
                mcause_q <= trap_cause_i;
            else if (accept && irq_take)
                mcause_q <= {1'b1, CAUSE_M_EXTERNAL[30:0]};  // interrupt flag in msb
            else if (accept && mret_i)
                mcause_q <= '0;
        end
    end

    always_comb begin
        mstatus_o                   = '0;
        mstatus_o[MSTATUS_MIE_BIT]  = mie_q;
        mstatus_o[MSTATUS_MPIE_BIT] = mpie_q;
    end

    assign mepc_o   = mepc_q;
    assign mcause_o = mcause_q;

endmodule

// File: hw/pmp_lookup.sv
`timescale 1ns/1ns

module pmp_lookup (
    input  csr_pkg::word_t addr_i,
    output logic [2:0]     rwx_o
);
    import csr_pkg::*;

    word_t word_addr;
    logic  found;

    assign word_addr = {2'b00, addr_i[31:2]};  // table holds word addresses

    // first hit in table order wins
    always_comb begin
        found = 1'b0;
        rwx_o = PMP_CFG[PMP_ENTRIES-1].rwx;  // catch-all entry
        for (int i = 0; i < PMP_ENTRIES - 1; i++) begin
            if (!found) begin
                if (PMP_CFG[i].mode == PMP_NA4) begin
                    if (word_addr == PMP_ADDR[i]) begin
                        rwx_o = PMP_CFG[i].rwx;
                        found = 1'b1;
                    end
                end else if (word_addr < PMP_ADDR[i+1]) begin
                    // range runs up to the next entry's address
                    rwx_o = PMP_CFG[i].rwx;
                    found = 1'b1;
                end
            end
        end
    end

endmodule

// File: hw/csr_unit.sv
`timescale 1ns/1ns

module csr_unit #(
    parameter csr_pkg::word_t HART_ID = 32'd0
) (
    input  logic               clk_i,
    input  logic               arst_n_i,
    input  logic               retired_i,
    input  logic               interrupt_i,
    input  logic               trap_i,
    input  csr_pkg::word_t     trap_pc_i,
    input  csr_pkg::word_t     trap_cause_i,
    input  logic               mret_i,
    input  logic               jmp_accept_i,
    input  logic               read_en_i,
    input  csr_pkg::csr_addr_e read_addr_i,
    input  logic               write_en_i,
    input  csr_pkg::csr_addr_e write_addr_i,
    input  csr_pkg::word_t     write_data_i,
    input  csr_pkg::word_t     lookup_a_addr_i,
    input  csr_pkg::word_t     lookup_b_addr_i,
    output logic               jmp_req_o,
    output csr_pkg::word_t     jmp_addr_o,
    output csr_pkg::word_t     read_data_o,
    output logic [2:0]         lookup_a_rwx_o,
    output logic [2:0]         lookup_b_rwx_o
);
    import csr_pkg::*;

    word_t  mtvec_q;
    word_t  mscratch_q;
    word_t  mcountinhibit_q;
    logic   msie_q;
    logic   mtie_q;
    logic   meie_q;
    word_t  read_data_q;

    logic   wr_mtvec, wr_mscratch, wr_inhibit, wr_mie;
    logic   wr_mstatus, wr_mepc;
    logic   wr_cycle_lo, wr_cycle_hi, wr_instret_lo, wr_instret_hi;
    logic   wr_time_lo, wr_time_hi;

    dword_t cycle, instret, time_cnt;
    word_t  mstatus, mepc, mcause;
    word_t  mie_word, mip_word;

    // one strobe per target register
    always_comb begin
        {wr_mtvec, wr_mscratch, wr_inhibit, wr_mie, wr_mstatus, wr_mepc} = '0;
        {wr_cycle_lo, wr_cycle_hi, wr_instret_lo, wr_instret_hi} = '0;
        {wr_time_lo, wr_time_hi} = '0;
        if (write_en_i) begin
            case (write_addr_i)
                CSR_MTVEC:                  wr_mtvec      = 1'b1;
                CSR_MSCRATCH:               wr_mscratch   = 1'b1;
                CSR_MCOUNTINHIBIT:          wr_inhibit    = 1'b1;
                CSR_MIE:                    wr_mie        = 1'b1;
                CSR_MSTATUS:                wr_mstatus    = 1'b1;
                CSR_MEPC:                   wr_mepc       = 1'b1;
                CSR_MCYCLE, CSR_CYCLE:      wr_cycle_lo   = 1'b1;
                CSR_MCYCLEH, CSR_CYCLEH:    wr_cycle_hi   = 1'b1;
                CSR_MINSTRET, CSR_INSTRET:  wr_instret_lo = 1'b1;
                CSR_MINSTRETH, CSR_INSTRETH: wr_instret_hi = 1'b1;
                CSR_TIME:                   wr_time_lo    = 1'b1;
                CSR_TIMEH:                  wr_time_hi    = 1'b1;
                default: ;                  // read-only or unimplemented
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mtvec_q         <= '0;
            mscratch_q      <= '0;
            mcountinhibit_q <= '0;
            msie_q          <= 1'b0;
            mtie_q          <= 1'b0;
            meie_q          <= 1'b0;
        end else begin
            if (wr_mtvec)
                mtvec_q <= write_data_i;
            if (wr_mscratch)
                mscratch_q <= write_data_i;
            if (wr_inhibit)
                mcountinhibit_q <= write_data_i;
            if (wr_mie) begin
                msie_q <= write_data_i[MIE_MSI_BIT];
                mtie_q <= write_data_i[MIE_MTI_BIT];
                meie_q <= write_data_i[MIE_MEI_BIT];
            end
        end
    end

    always_comb begin
        mie_word              = '0;
        mie_word[MIE_MSI_BIT] = msie_q;
        mie_word[MIE_MTI_BIT] = mtie_q;
        mie_word[MIE_MEI_BIT] = meie_q;
        mip_word              = '0;  // timer and software pending stay low
        mip_word[MIE_MEI_BIT] = interrupt_i;
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            read_data_q <= '0;
        end else if (read_en_i) begin
            case (read_addr_i)
                CSR_MSTATUS:                 read_data_q <= mstatus;
                CSR_MISA:                    read_data_q <= MISA_VALUE;
                CSR_MIE:                     read_data_q <= mie_word;
                CSR_MTVEC:                   read_data_q <= mtvec_q;
                CSR_MCOUNTINHIBIT:           read_data_q <= mcountinhibit_q;
                CSR_MSCRATCH:                read_data_q <= mscratch_q;
                CSR_MEPC:                    read_data_q <= mepc;
                CSR_MCAUSE:                  read_data_q <= mcause;
                CSR_MIP:                     read_data_q <= mip_word;
                CSR_PMPCFG0:  read_data_q <= {PMP_CFG[3], PMP_CFG[2], PMP_CFG[1], PMP_CFG[0]};
                CSR_PMPCFG1:  read_data_q <= {PMP_CFG[7], PMP_CFG[6], PMP_CFG[5], PMP_CFG[4]};
                CSR_PMPCFG2:  read_data_q <= {24'd0, PMP_CFG[8]};
                CSR_PMPADDR0:                read_data_q <= PMP_ADDR[0];
                CSR_PMPADDR1:                read_data_q <= PMP_ADDR[1];
                CSR_PMPADDR2:                read_data_q <= PMP_ADDR[2];
                CSR_PMPADDR3:                read_data_q <= PMP_ADDR[3];
                CSR_PMPADDR4:                read_data_q <= PMP_ADDR[4];
                CSR_PMPADDR5:                read_data_q <= PMP_ADDR[5];
                CSR_PMPADDR6:                read_data_q <= PMP_ADDR[6];
                CSR_PMPADDR7:                read_data_q <= PMP_ADDR[7];
                CSR_PMPADDR8:                read_data_q <= PMP_ADDR[8];
                CSR_MCYCLE, CSR_CYCLE:       read_data_q <= cycle[31:0];
                CSR_MCYCLEH, CSR_CYCLEH:     read_data_q <= cycle[63:32];
                CSR_MINSTRET, CSR_INSTRET:   read_data_q <= instret[31:0];
                CSR_MINSTRETH, CSR_INSTRETH: read_data_q <= instret[63:32];
                CSR_TIME:                    read_data_q <= time_cnt[31:0];
                CSR_TIMEH:                   read_data_q <= time_cnt[63:32];
                CSR_MIMPID:                  read_data_q <= MIMPID_VALUE;
                CSR_MHARTID:                 read_data_q <= HART_ID;
                default:                     read_data_q <= '0;  // vendor/arch id read zero too
            endcase
        end else begin
            read_data_q <= '0;
        end
    end

    assign read_data_o = read_data_q;

    csr_counters u_counters (
        .clk_i           (clk_i),
        .arst_n_i        (arst_n_i),
        .retired_i       (retired_i),
        .inhibit_i       (mcountinhibit_q),
        .wr_data_i       (write_data_i),
        .wr_cycle_lo_i   (wr_cycle_lo),
        .wr_cycle_hi_i   (wr_cycle_hi),
        .wr_instret_lo_i (wr_instret_lo),
        .wr_instret_hi_i (wr_instret_hi),
        .wr_time_lo_i    (wr_time_lo),
        .wr_time_hi_i    (wr_time_hi),
        .cycle_o         (cycle),
        .instret_o       (instret),
        .time_o          (time_cnt)
    );

    csr_trap_ctrl u_trap_ctrl (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .interrupt_i  (interrupt_i),
        .meie_i       (meie_q),
        .mtvec_i      (mtvec_q),
        .trap_i       (trap_i),
        .trap_pc_i    (trap_pc_i),
        .trap_cause_i (trap_cause_i),
        .mret_i       (mret_i),
        .jmp_accept_i (jmp_accept_i),
        .wr_data_i    (write_data_i),
        .wr_mstatus_i (wr_mstatus),
        .wr_mepc_i    (wr_mepc),
        .jmp_req_o    (jmp_req_o),
        .jmp_addr_o   (jmp_addr_o),
        .mstatus_o    (mstatus),
        .mepc_o       (mepc),
        .mcause_o     (mcause)
    );

    pmp_lookup u_pmp_a (
        .addr_i (lookup_a_addr_i),
        .rwx_o  (lookup_a_rwx_o)
    );

    pmp_lookup u_pmp_b (
        .addr_i (lookup_b_addr_i),
        .rwx_o  (lookup_b_rwx_o)
    );

endmodule

// File: sim/csr_model.svh
`ifndef CSR_MODEL_SVH
`define CSR_MODEL_SVH

// reference copy of the architectural CSR state
logic [63:0] ref_cycle;
logic [63:0] ref_instret;
logic [63:0] ref_time;
logic [31:0] ref_inhibit;
logic [31:0] ref_mtvec;
logic [31:0] ref_mscratch;
logic [31:0] ref_mie_reg;      // only MSI, MTI and MEI survive a write
logic        ref_status_mie;
logic        ref_status_mpie;
logic [31:0] ref_mepc;
logic [31:0] ref_mcause;
logic [31:0] ref_read_data;    // what read_data_o must show this cycle
logic [11:0] ref_read_addr;
logic        ref_read_en;

task automatic clear_model();
    ref_cycle       = '0;
    ref_instret     = '0;
    ref_time        = '0;
    ref_inhibit     = '0;
    ref_mtvec       = '0;
    ref_mscratch    = '0;
    ref_mie_reg     = '0;
    ref_status_mie  = 1'b0;
    ref_status_mpie = 1'b0;
    ref_mepc        = '0;
    ref_mcause      = '0;
    ref_read_data   = '0;
    ref_read_addr   = '0;
    ref_read_en     = 1'b0;
endtask

// value of a CSR as the architecture defines it for this core
function automatic logic [31:0] read_value(input logic [11:0] addr, input logic irq);
    case (addr)
        12'h300: return {24'd0, ref_status_mpie, 3'd0, ref_status_mie, 3'd0};
        12'h301: return 32'h4000_0100;  // RV32I
        12'h304: return ref_mie_reg;
        12'h305: return ref_mtvec;
        12'h320: return ref_inhibit;
        12'h340: return ref_mscratch;
        12'h341: return ref_mepc;
        12'h342: return ref_mcause;
        12'h344: return {20'd0, irq, 11'd0};  // external pending only
        12'h3A0: return 32'h809B_809D;        // locked cfg bytes of entries 0..3
        12'h3A1: return 32'h9193_809B;
        12'h3A2: return 32'h0000_0088;
        12'h3B0: return 32'h0000_0000;
        12'h3B1: return 32'h0000_0400;
        12'h3B2: return 32'h0400_0000;
        12'h3B3: return 32'h0400_0400;
        12'h3B4: return 32'h0800_0000;
        12'h3B5: return 32'h0800_0400;
        12'h3B6: return 32'h3FC0_0001;
        12'h3B7: return 32'h3FC0_0002;
        12'h3B8: return 32'h3FFF_FFFF;
        12'hB00, 12'hC00: return ref_cycle[31:0];
        12'hB80, 12'hC80: return ref_cycle[63:32];
        12'hB02, 12'hC02: return ref_instret[31:0];
        12'hB82, 12'hC82: return ref_instret[63:32];
        12'hC01: return ref_time[31:0];
        12'hC81: return ref_time[63:32];
        12'hF13: return 32'd1;
        12'hF14: return TEST_HART_ID;
        default: return 32'd0;
    endcase
endfunction

function automatic logic jump_requested();
    return trap_i || mret_i || (interrupt_i && ref_mie_reg[11] && ref_status_mie);
endfunction

function automatic logic [31:0] jump_target();
    logic irq_taken;
    irq_taken = interrupt_i && ref_mie_reg[11] && ref_status_mie;
    if (trap_i)
        return {ref_mtvec[31:2], 2'b00};
    if (irq_taken)
        return {ref_mtvec[31:2], 2'b00} + ((ref_mtvec[1:0] == 2'd1) ? 32'd44 : 32'd0);
    if (mret_i)
        return ref_mepc;
    return 32'd0;
endfunction

// memory map of the fixed protection layout, in byte addresses
function automatic logic [2:0] table_rwx(input logic [31:0] addr);
    if (addr < 32'h0000_1000)
        return 3'b101;  // bios, R+X
    if (addr >= 32'h1000_0000 && addr < 32'h1000_1000)
        return 3'b011;
    if (addr >= 32'h2000_0000 && addr < 32'h2000_1000)
        return 3'b011;
    if (addr >= 32'hFF00_0004 && addr < 32'hFF00_0008)
        return 3'b011;
    if (addr >= 32'hFF00_0008 && addr < 32'hFF00_000C)
        return 3'b001;
    return 3'b000;
endfunction

// one clock edge with the inputs held during the cycle before it
task automatic advance_model();
    logic        irq_taken;
    logic        trap_taken;
    logic        taken;
    logic [11:0] waddr;
    logic [63:0] cyc_next;
    logic [63:0] ins_next;
    logic [63:0] tim_next;
    irq_taken  = interrupt_i && ref_mie_reg[11] && ref_status_mie;
    trap_taken = trap_i || irq_taken;
    taken      = jmp_accept_i && (trap_taken || mret_i);
    waddr      = write_addr_i;

    ref_read_en   = read_en_i;
    ref_read_addr = read_addr_i;
    ref_read_data = read_en_i ? read_value(read_addr_i, interrupt_i) : 32'd0;

    cyc_next = ref_inhibit[0] ? ref_cycle : ref_cycle + 64'd1;
    ins_next = (retired_i && !ref_inhibit[2]) ? ref_instret + 64'd1 : ref_instret;
    tim_next = ref_time + 64'd1;

    if (taken && trap_taken) begin
        ref_status_mpie = ref_status_mie;
        ref_status_mie  = 1'b0;
        ref_mepc        = trap_pc_i;
        ref_mcause      = trap_i ? trap_cause_i : 32'h8000_000B;
    end else if (taken) begin  // mret
        ref_status_mie  = ref_status_mpie;
        ref_status_mpie = 1'b1;
        ref_mepc        = 32'd0;
        ref_mcause      = 32'd0;
    end

    // a csr write lands after the trap update and so overrides it
    if (write_en_i) begin
        case (waddr)
            12'h300: begin
                ref_status_mie  = write_data_i[3];
                ref_status_mpie = write_data_i[7];
            end
            12'h304: ref_mie_reg  = write_data_i & 32'h0000_0888;
            12'h305: ref_mtvec    = write_data_i;
            12'h320: ref_inhibit  = write_data_i;
            12'h340: ref_mscratch = write_data_i;
            12'h341: ref_mepc     = write_data_i;
            12'hB00, 12'hC00: cyc_next[31:0]  = write_data_i;
            12'hB80, 12'hC80: cyc_next[63:32] = write_data_i;
            12'hB02, 12'hC02: ins_next[31:0]  = write_data_i;
            12'hB82, 12'hC82: ins_next[63:32] = write_data_i;
            12'hC01: tim_next[31:0]  = write_data_i;
            12'hC81: tim_next[63:32] = write_data_i;
            default: ;
        endcase
    end

    ref_cycle   = cyc_next;
    ref_instret = ins_next;
    ref_time    = tim_next;
endtask

`endif

// File: sim/csr_unit_tb.sv
`timescale 1ns/1ns

module csr_unit_tb;
    import csr_pkg::*;

    localparam int          NUM_CYCLES   = 3000;
    localparam longint      TIMEOUT_NS   = (NUM_CYCLES + 23) * 100;
    localparam logic [31:0] TEST_HART_ID = 32'h0000_0005;

    // implemented addresses first, then a few that are not
    localparam logic [11:0] CSR_POOL [0:38] = '{
        12'h300, 12'h301, 12'h304, 12'h305, 12'h320, 12'h340, 12'h341, 12'h342, 12'h344,
        12'h3A0, 12'h3A1, 12'h3A2,
        12'h3B0, 12'h3B1, 12'h3B2, 12'h3B3, 12'h3B4, 12'h3B5, 12'h3B6, 12'h3B7, 12'h3B8,
        12'hB00, 12'hB02, 12'hB80, 12'hB82,
        12'hC00, 12'hC01, 12'hC02, 12'hC80, 12'hC81, 12'hC82,
        12'hF11, 12'hF12, 12'hF13, 12'hF14,
        12'h343, 12'h3A3, 12'h7C0, 12'hFFF
    };

    // region edges and the two single words
    localparam logic [31:0] EDGE_POOL [0:15] = '{
        32'h0000_0000, 32'h0000_0FFC, 32'h0000_1000, 32'h0FFF_FFFC,
        32'h1000_0000, 32'h1000_0FFC, 32'h1000_1000, 32'h1FFF_FFFC,
        32'h2000_0000, 32'h2000_0FFC, 32'h2000_1000, 32'hFF00_0000,
        32'hFF00_0004, 32'hFF00_0008, 32'hFF00_000C, 32'hFFFF_FFFC
    };

    logic        clk_i = 1'b0;
    logic        arst_n_i;
    logic        retired_i;
    logic        interrupt_i;
    logic        trap_i;
    word_t       trap_pc_i;
    word_t       trap_cause_i;
    logic        mret_i;
    logic        jmp_accept_i;
    logic        read_en_i;
    csr_addr_e   read_addr_i;
    logic        write_en_i;
    csr_addr_e   write_addr_i;
    word_t       write_data_i;
    word_t       lookup_a_addr_i;
    word_t       lookup_b_addr_i;
    logic        jmp_req_o;
    word_t       jmp_addr_o;
    word_t       read_data_o;
    logic [2:0]  lookup_a_rwx_o;
    logic [2:0]  lookup_b_rwx_o;

    `include "csr_model.svh"

    csr_unit #(.HART_ID(TEST_HART_ID)) dut_i (
        .clk_i           (clk_i),
        .arst_n_i        (arst_n_i),
        .retired_i       (retired_i),
        .interrupt_i     (interrupt_i),
        .trap_i          (trap_i),
        .trap_pc_i       (trap_pc_i),
        .trap_cause_i    (trap_cause_i),
        .mret_i          (mret_i),
        .jmp_accept_i    (jmp_accept_i),
        .read_en_i       (read_en_i),
        .read_addr_i     (read_addr_i),
        .write_en_i      (write_en_i),
        .write_addr_i    (write_addr_i),
        .write_data_i    (write_data_i),
        .lookup_a_addr_i (lookup_a_addr_i),
        .lookup_b_addr_i (lookup_b_addr_i),
        .jmp_req_o       (jmp_req_o),
        .jmp_addr_o      (jmp_addr_o),
        .read_data_o     (read_data_o),
        .lookup_a_rwx_o  (lookup_a_rwx_o),
        .lookup_b_rwx_o  (lookup_b_rwx_o)
    );

    always #50 clk_i = ~clk_i;

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else begin
            $display("[FAIL] %s: expected 0x%08h, actual 0x%08h", name, exp, act);
            $display("Simulation FAILED");
            $fatal(1, "output mismatch");
        end
    endtask

    // all outputs are settled by the falling edge
    task automatic compare_outputs();
        logic req;
        req = jump_requested();
        check_value("jmp_req", 32'(req), 32'(jmp_req_o));
        if (req)
            check_value("jmp_addr", jump_target(), jmp_addr_o);
        check_value($sformatf("read_data en %0d addr %03h", ref_read_en, ref_read_addr),
                    ref_read_data, read_data_o);
        check_value($sformatf("lookup_a %08h", lookup_a_addr_i),
                    {29'd0, table_rwx(lookup_a_addr_i)}, {29'd0, lookup_a_rwx_o});
        check_value($sformatf("lookup_b %08h", lookup_b_addr_i),
                    {29'd0, table_rwx(lookup_b_addr_i)}, {29'd0, lookup_b_rwx_o});
    endtask

    function automatic csr_addr_e choose_csr_addr();
        logic [5:0] idx;
        idx = 6'($urandom_range(38));
        return csr_addr_e'(CSR_POOL[idx]);
    endfunction

    function automatic logic [31:0] write_pattern();
        int unsigned r;
        r = $urandom_range(99);
        if (r < 10)
            return 32'hFFFF_FFFF;  // forces carries into the high half
        if (r < 20)
            return 32'hFFFF_FFFE;
        return $urandom();
    endfunction

    function automatic logic [31:0] lookup_probe();
        logic [3:0] idx;
        if ($urandom_range(3) == 0)
            return $urandom();
        idx = 4'($urandom_range(15));
        return EDGE_POOL[idx] + $urandom_range(7) - 32'd4;  // a word either side
    endfunction

    task automatic drive_inputs();
        retired_i       <= ($urandom_range(1) == 1);
        interrupt_i     <= ($urandom_range(2) == 0);
        trap_i          <= ($urandom_range(9) == 0);
        mret_i          <= ($urandom_range(11) == 0);
        jmp_accept_i    <= ($urandom_range(1) == 1);
        trap_pc_i       <= $urandom() & 32'hFFFF_FFFC;
        trap_cause_i    <= $urandom_range(15);
        read_en_i       <= ($urandom_range(3) != 0);
        read_addr_i     <= choose_csr_addr();
        write_en_i      <= ($urandom_range(2) == 0);
        write_addr_i    <= choose_csr_addr();
        write_data_i    <= write_pattern();
        lookup_a_addr_i <= lookup_probe();
        lookup_b_addr_i <= lookup_probe();
    endtask

    initial begin
        void'($urandom(50980));
        arst_n_i        = 1'b0;
        retired_i       = 1'b0;
        interrupt_i     = 1'b0;
        trap_i          = 1'b0;
        trap_pc_i       = '0;
        trap_cause_i    = '0;
        mret_i          = 1'b0;
        jmp_accept_i    = 1'b0;
        read_en_i       = 1'b0;
        read_addr_i     = CSR_MSTATUS;
        write_en_i      = 1'b0;
        write_addr_i    = CSR_MSTATUS;
        write_data_i    = '0;
        lookup_a_addr_i = '0;
        lookup_b_addr_i = '0;
        clear_model();

        repeat (3) @(posedge clk_i);
        arst_n_i <= 1'b1;

        for (int n = 0; n < NUM_CYCLES; n++) begin
            @(negedge clk_i);
            compare_outputs();
            @(posedge clk_i);
            advance_model();  // sees the inputs of the cycle that just ended
            drive_inputs();
        end
        @(negedge clk_i);
        compare_outputs();

        $display("Simulation PASSED");
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired before the stimulus loop finished");
        $display("Simulation FAILED");
        $fatal(1, "timeout");
    end

endmodule

// File: project.f
+incdir+sim
hw/csr_pkg.sv
hw/csr_counters.sv
hw/csr_trap_ctrl.sv
hw/pmp_lookup.sv
hw/csr_unit.sv
sim/csr_unit_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the CSR unit testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

LOG_FILE=sim.log
FAIL_TEXT="Simulation FAILED"

if ! verilator --binary --timing --assert --top-module csr_unit_tb \
        -f project.f -o csr_unit_sim; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/csr_unit_sim > "$LOG_FILE" 2>&1
run_status=$?
cat "$LOG_FILE"

if grep -q "$FAIL_TEXT" "$LOG_FILE"; then
    echo "simulation reported a failure, see $LOG_FILE"
    exit 1
fi

if [ "$run_status" -ne 0 ]; then
    echo "simulator exited with status $run_status"
    exit 1
fi

echo "simulation finished without failures"
exit 0
